/* files.f */
logic/mapper_pkg.sv
logic/cart_regs.sv
logic/bank_decode.sv
logic/flash_emu.sv
logic/bus_response.sv
logic/cart_mapper.sv
sim/cart_mapper_checker.sv
sim/tb_cart_mapper.sv

/* sim/tb_cart_mapper.sv */
`timescale 1ns/100ps

module tb_cart_mapper;

    typedef struct packed {
        mapper_pkg::cart_bus_t                bus;
        mapper_pkg::mem_sel_t                 mem;
        logic [mapper_pkg::ADDR_EXT_W-1:0]    addr_ext;
        logic [7:0]                           rdata;
        logic                                 rdata_oe;
        // bit 0 selects, bit 1 addr_ext, bit 2 read data
        logic [2:0]                           mask;
    } row_t;

    localparam mapper_pkg::cart_bus_t IDLE_BUS = {4'b1111, 21'd0};

    logic                              SClk;
    logic                              rst_n;
    mapper_pkg::cart_bus_t             bus;
    mapper_pkg::mem_sel_t              mem;
    logic [mapper_pkg::ADDR_EXT_W-1:0] addr_ext;
    logic [7:0]                        rdata;
    logic                              rdata_oe;

    row_t        rows[$];
    logic [15:0] lfsr = 16'd11846;
    int          cycles = 0;
    int          limit = 0;

    // expected bank state, index 0 ram, 1 rom0, 2 rom1
    logic [9:0] m_bank [3];
    logic [2:0] m_apply;
    logic [7:0] m_lin;
    logic [8:0] m_rmask;
    logic [3:0] m_amask;
    logic       m_sf = 1'b0;
    logic       m_sram = 1'b1;

    cart_mapper dut0 (
        .SClk     (SClk),
        .rst_n    (rst_n),
        .bus      (bus),
        .mem      (mem),
        .addr_ext (addr_ext),
        .rdata    (rdata),
        .rdata_oe (rdata_oe)
    );

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        int         i;
        v = 8'h00;
        for (i = 0; i < n; i++) begin
            v = {v[6:0], lfsr[0]};
            lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hB400 : 16'h0000);
        end
        return v;
    endfunction

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_mem(input mapper_pkg::mem_sel_t exp);
        if (mem !== exp) begin
            fail_now($sformatf("[FAIL] %0t selects got %b, expected %b", $time, mem, exp));
        end
    endtask

    task automatic check_addr(input logic [mapper_pkg::ADDR_EXT_W-1:0] exp);
        if (addr_ext !== exp) begin
            fail_now($sformatf("[FAIL] %0t addr_ext got %h, expected %h", $time, addr_ext, exp));
        end
    endtask

    task automatic check_rdata(input logic [7:0] exp, input logic exp_oe);
        if (rdata_oe !== exp_oe || (exp_oe && rdata !== exp)) begin
            fail_now($sformatf("[FAIL] %0t rdata %h oe %b, expected %h oe %b",
                               $time, rdata, rdata_oe, exp, exp_oe));
        end
    endtask

    task automatic add_access(input logic io, input logic write, input logic [3:0] hi,
                              input logic [8:0] lo, input logic [7:0] data,
                              input mapper_pkg::mem_sel_t exp_mem, input logic [6:0] exp_addr,
                              input logic [7:0] exp_rdata, input logic exp_oe,
                              input logic [2:0] mask);
        rows.push_back(row_t'({1'b0, write, ~write, ~io, hi, lo, data,
                               exp_mem, exp_addr, exp_rdata, exp_oe, mask}));
    endtask

    task automatic io_wr(input logic [7:0] port, input logic [7:0] data);
        add_access(1'b1, 1'b1, port[7:4], {5'd0, port[3:0]}, data, '1, '0, 8'h00, 1'b0, 3'b000);
    endtask

    task automatic io_rd(input logic [7:0] port, input logic [7:0] exp, input logic exp_oe);
        add_access(1'b1, 1'b0, port[7:4], {5'd0, port[3:0]}, 8'h00, '1, '0, exp, exp_oe, 3'b100);
    endtask

    // RAM window write that reaches the PSRAM only when pass is set
    task automatic mem_wr(input logic [3:0] hi, input logic [7:0] data, input logic pass);
        add_access(1'b0, 1'b1, hi, 9'd0, data, {~pass, 4'b1101}, '0, 8'h00, 1'b0, 3'b001);
    endtask

    // RAM window read while the flash emulation hides the PSRAM
    task automatic blocked_rd(input logic [7:0] catch_val);
        add_access(1'b0, 1'b0, 4'h1, 9'd0, 8'h00, 5'b11101, 7'h05, catch_val, 1'b1, 3'b111);
    endtask

    // memory read with selects and address worked out from the bank state
    task automatic mem_rd(input logic [3:0] hi, input logic lo0);
        logic [8:0]           rom;
        logic [3:0]           ram;
        logic                 apply;
        logic                 rom_sp;
        mapper_pkg::mem_sel_t m;
        if (hi < 4) begin
            rom = m_bank[hi - 1][8:0];
            apply = m_apply[hi - 1];
        end else begin
            rom = {m_lin[4:0], hi};
            apply = 1'b1;
        end
        ram = m_bank[0][3:0];
        if (apply) begin
            rom = rom & m_rmask;
            ram = ram & m_amask;
        end
        rom_sp = (hi != 4'h1) || m_sf;
        m.psram1_sel_n = !(rom_sp && rom[8:7] == 2'b00);
        m.psram2_sel_n = !(rom_sp && rom[8:7] == 2'b01);
        m.sram_sel_n = !(!rom_sp && !ram[3] && m_sram);
        m.psram_lb_n = (hi == 4'h1) && lo0;
        m.psram_ub_n = (hi == 4'h1) && !lo0;
        add_access(1'b0, 1'b0, hi, {8'd0, lo0}, 8'h00, m,
                   {rom[6:3], rom_sp ? rom[2:0] : ram[2:0]}, 8'h00, 1'b0, 3'b111);
    endtask

    task automatic bank_wr(input logic [7:0] port, input logic [7:0] data);
        case (port)
            8'hC0: m_lin = data;
            8'hC1: m_bank[0][7:0] = data;
            8'hC2: m_bank[1][7:0] = data;
            8'hC3: m_bank[2][7:0] = data;
            8'hD1: m_bank[0][9:8] = data[1:0];
            8'hD3: m_bank[1][9:8] = data[1:0];
            8'hD5: m_bank[2][9:8] = data[1:0];
            8'hCE: m_sf = data[0];
            8'hE2: m_sram = data[6];
            8'hE4: m_rmask[7:0] = data;
            8'hE5: {m_amask, m_apply[0], m_apply[2], m_apply[1], m_rmask[8]} = data;
            default: begin
            end
        endcase
        io_wr(port, data);
    endtask

    // apply holds the ram, rom1 and rom0 mask enables
    task automatic random_banks(input logic [2:0] apply);
        logic [7:0] v;
        int         w;
        bank_wr(8'hC0, rand_bits(8));
        bank_wr(8'hC1, rand_bits(8));
        bank_wr(8'hC2, rand_bits(8));
        bank_wr(8'hC3, rand_bits(8));
        bank_wr(8'hD1, rand_bits(2));
        bank_wr(8'hD3, rand_bits(2));
        bank_wr(8'hD5, rand_bits(2));
        bank_wr(8'hE4, rand_bits(8));
        v = rand_bits(5);
        bank_wr(8'hE5, {v[4:1], apply, v[0]});
        for (w = 1; w < 16; w++) begin
            v = rand_bits(1);
            mem_rd(w[3:0], v[0]);
        end
    endtask

    task automatic build_table();
        // values after reset
        io_rd(8'hC1, 8'hFF, 1'b1);
        io_rd(8'hC2, 8'hFF, 1'b1);
        io_rd(8'hC3, 8'hFF, 1'b1);
        io_rd(8'hE2, 8'h5C, 1'b1);
        io_rd(8'hE4, 8'hFF, 1'b1);
        io_rd(8'hC8, 8'h00, 1'b0);
        // bank register round trip
        io_wr(8'hC1, 8'h5A);
        io_rd(8'hC1, 8'h5A, 1'b1);
        io_rd(8'hD0, 8'h5A, 1'b1);
        io_wr(8'hD3, 8'hFE);
        io_rd(8'hD3, 8'h02, 1'b1);
        io_wr(8'hD4, 8'h3C);
        io_rd(8'hC3, 8'h3C, 1'b1);
        io_rd(8'hD4, 8'h3C, 1'b1);
        io_wr(8'hE2, 8'h4C);
        io_wr(8'hD0, 8'h11);
        io_rd(8'hD0, 8'h5A, 1'b1);
        io_wr(8'hC1, 8'h22);
        io_rd(8'hD0, 8'h22, 1'b1);
        io_wr(8'hE2, 8'h5C);
        // power control lock and FD unlock
        io_wr(8'hE2, 8'h58);
        io_wr(8'hE4, 8'h12);
        io_rd(8'hE4, 8'hFF, 1'b1);
        io_wr(8'hE2, 8'h5C);
        io_rd(8'hE2, 8'h58, 1'b1);
        io_wr(8'hE2, 8'hFD);
        io_rd(8'hE2, 8'h5C, 1'b1);
        io_wr(8'hE4, 8'h12);
        io_rd(8'hE4, 8'h12, 1'b1);
        // address translation, masked then unmasked
        random_banks(3'b111);
        random_banks(3'b000);
        // SRAM select and byte lanes in the RAM window
        bank_wr(8'hE4, 8'hFF);
        bank_wr(8'hE5, 8'hFF);
        bank_wr(8'hC1, 8'h03);
        mem_rd(4'h1, 1'b0);
        mem_rd(4'h1, 1'b1);
        bank_wr(8'hC1, 8'h0B);
        mem_rd(4'h1, 1'b0);
        bank_wr(8'hC1, 8'h03);
        bank_wr(8'hE2, 8'h1C);
        mem_rd(4'h1, 1'b0);
        bank_wr(8'hE2, 8'h5C);
        bank_wr(8'hCE, 8'h01);
        mem_rd(4'h1, 1'b1);
        // flash emulation in the RAM window
        bank_wr(8'hC1, 8'h05);
        bank_wr(8'hD1, 8'h00);
        io_wr(8'hE6, 8'h04);
        mem_rd(4'h1, 1'b0);
        mem_wr(4'h1, 8'hAA, 1'b0);
        mem_wr(4'h1, 8'h55, 1'b0);
        mem_wr(4'h1, 8'h20, 1'b0);
        blocked_rd(8'h00);
        mem_wr(4'h1, 8'hA0, 1'b0);
        mem_rd(4'h1, 1'b0);
        mem_wr(4'h1, 8'h33, 1'b1);
        blocked_rd(8'h00);
        mem_wr(4'h1, 8'h90, 1'b0);
        mem_rd(4'h1, 1'b0);
        mem_wr(4'h1, 8'hAA, 1'b0);
        mem_wr(4'h1, 8'h55, 1'b0);
        mem_wr(4'h1, 8'h30, 1'b0);
        blocked_rd(8'hFF);
        mem_wr(4'h1, 8'hAA, 1'b0);
        mem_rd(4'h1, 1'b0);
    endtask

    initial begin
        SClk = 1'b0;
        forever #10 SClk = ~SClk;
    end

    always @(posedge SClk) begin
        cycles++;
        if (cycles > limit) begin
            fail_now("timeout: the stimulus table did not finish in time");
        end
    end

    initial begin
        rst_n = 1'b0;
        bus = IDLE_BUS;
        build_table();
        // one cycle per row plus reset and some margin
        limit = rows.size() + 10 + 20;
        repeat (10) @(posedge SClk);
        @(negedge SClk);
        rst_n = 1'b1;
        foreach (rows[i]) begin
            @(negedge SClk);
            bus = rows[i].bus;
            #5;
            if (rows[i].mask[0]) check_mem(rows[i].mem);
            if (rows[i].mask[1]) check_addr(rows[i].addr_ext);
            if (rows[i].mask[2]) check_rdata(rows[i].rdata, rows[i].rdata_oe);
            if (dut0.chk0.failures != 0) fail_now("a bus checker assertion failed");
        end
        @(negedge SClk);
        bus = IDLE_BUS;
        @(negedge SClk);
        if (dut0.chk0.failures == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            fail_now("a bus checker assertion failed");
        end
    end

endmodule

/* sim/cart_mapper_checker.sv */
`timescale 1ns/100ps

module cart_mapper_checker (
    input logic                  SClk,
    input logic                  rst_n,
    input mapper_pkg::cart_bus_t bus,
    input mapper_pkg::mem_sel_t  mem,
    input logic                  rdata_oe
);

    int failures = 0;

    // one memory device at a time
    selects_exclusive: assert property (@(posedge SClk) disable iff (!rst_n)
        $onehot0({~mem.psram1_sel_n, ~mem.psram2_sel_n, ~mem.sram_sel_n}))
    else begin
        $error("more than one chip select is active");
        failures++;
    end

    selects_idle: assert property (@(posedge SClk) disable iff (!rst_n)
        bus.sel_n |-> (mem.psram1_sel_n && mem.psram2_sel_n && mem.sram_sel_n))
    else begin
        $error("a chip select is active while the cartridge is not selected");
        failures++;
    end

    oe_needs_read: assert property (@(posedge SClk) disable iff (!rst_n)
        rdata_oe |-> !bus.oe_n)
    else begin
        $error("read data driven without a read strobe");
        failures++;
    end

endmodule

bind cart_mapper cart_mapper_checker chk0 (
    .SClk     (SClk),
    .rst_n    (rst_n),
    .bus      (bus),
    .mem      (mem),
    .rdata_oe (rdata_oe)
);

/* logic/cart_mapper.sv */
`timescale 1ns/100ps

module cart_mapper (
    input  logic                                SClk,
    input  logic                                rst_n,
    input  mapper_pkg::cart_bus_t               bus,
    output mapper_pkg::mem_sel_t                mem,
    output logic [mapper_pkg::ADDR_EXT_W-1:0]   addr_ext,
    output logic [7:0]                          rdata,
    output logic                                rdata_oe
);

    mapper_pkg::bank_state_t bank;
    mapper_pkg::region_t     region;
    logic                    flash_emu_enabled;
    logic [7:0]              reg_rdata;
    logic                    reg_ack;
    logic                    pass_read;
    logic                    pass_write;
    logic [7:0]              catch_val;

    cart_regs u_regs (
        .SClk              (SClk),
        .rst_n             (rst_n),
        .bus               (bus),
        .bank              (bank),
        .flash_emu_enabled (flash_emu_enabled),
        .reg_rdata         (reg_rdata),
        .reg_ack           (reg_ack)
    );

    bank_decode u_decode (
        .bus      (bus),
        .bank     (bank),
        .region   (region),
        .addr_ext (addr_ext)
    );

    flash_emu u_flash (
        .SClk              (SClk),
        .rst_n             (rst_n),
        .bus               (bus),
        .region            (region),
        .flash_emu_enabled (flash_emu_enabled),
        .pass_read         (pass_read),
        .pass_write        (pass_write),
        .catch_val         (catch_val)
    );

    bus_response u_resp (
        .bus        (bus),
        .region     (region),
        .pass_read  (pass_read),
        .pass_write (pass_write),
        .catch_val  (catch_val),
        .reg_rdata  (reg_rdata),
        .reg_ack    (reg_ack),
        .mem        (mem),
        .rdata      (rdata),
        .rdata_oe   (rdata_oe)
    );

endmodule

/* logic/bus_response.sv */
`timescale 1ns/100ps

module bus_response (
    input  mapper_pkg::cart_bus_t bus,
    input  mapper_pkg::region_t   region,
    input  logic                  pass_read,
    input  logic                  pass_write,
    input  logic [7:0]            catch_val,
    input  logic [7:0]            reg_rdata,
    input  logic                  reg_ack,
    output mapper_pkg::mem_sel_t  mem,
    output logic [7:0]            rdata,
    output logic                  rdata_oe
);

    logic mem_access;
    logic psram_hit;
    logic psram_ok;
    logic io_read;
    logic catch_read;

    assign mem_access = ~bus.sel_n & bus.io_n;
    assign psram_hit  = region.psram1_hit | region.psram2_hit;

    // flash emulation can hold back either direction
    assign psram_ok = mem_access &
        ((~bus.oe_n & pass_read) | (~bus.we_n & pass_write));

    always_comb begin
        mem.psram1_sel_n = ~(psram_ok & region.psram1_hit);
        mem.psram2_sel_n = ~(psram_ok & region.psram2_hit);
        mem.sram_sel_n   = ~(mem_access & region.sram_hit & (~bus.oe_n | ~bus.we_n));
        // byte lanes only split inside the RAM window
        mem.psram_lb_n   = region.in_ram_area & bus.addr_lo[0];
        mem.psram_ub_n   = region.in_ram_area & ~bus.addr_lo[0];
    end

    assign io_read    = ~bus.sel_n & ~bus.io_n & ~bus.oe_n & reg_ack;
    assign catch_read = mem_access & ~bus.oe_n & ~pass_read & psram_hit;

    always_comb begin
        if (io_read) begin
            rdata = reg_rdata;
        end else if (catch_read) begin
            rdata = catch_val;
        end else begin
            rdata = 8'h00;
        end
    end

    assign rdata_oe = io_read | catch_read;

endmodule

/* logic/flash_emu.sv */
`timescale 1ns/100ps

module flash_emu (
    input  logic                  SClk,
    input  logic                  rst_n,
    input  mapper_pkg::cart_bus_t bus,
    input  mapper_pkg::region_t   region,
    input  logic                  flash_emu_enabled,
    output logic                  pass_read,
    output logic                  pass_write,
    output logic [7:0]            catch_val
);

    mapper_pkg::flash_state_e state;
    logic                     step;

    // only memory writes that land in PSRAM drive the command sequence
    assign step = ~bus.sel_n & ~bus.we_n & bus.io_n & (region.psram1_hit | region.psram2_hit);

    always_ff @(posedge SClk or negedge rst_n) begin
        if (!rst_n) begin
            state <= mapper_pkg::WAIT_AA;
        end else if (step) begin
            case (state)
                mapper_pkg::WAIT_AA:
                    if (bus.wdata == mapper_pkg::FLASH_UNLOCK1) state <= mapper_pkg::WAIT_55;
                mapper_pkg::WAIT_55:
                    if (bus.wdata == mapper_pkg::FLASH_UNLOCK2) state <= mapper_pkg::CMD;
                    else state <= mapper_pkg::WAIT_AA;
                mapper_pkg::CMD: begin
                    case (bus.wdata)
                        mapper_pkg::FLASH_CMD_FAST:         state <= mapper_pkg::FAST;
                        mapper_pkg::FLASH_CMD_PROGRAM:      state <= mapper_pkg::SINGLE_WRITE;
                        mapper_pkg::FLASH_CMD_ERASE_SECTOR,
                        mapper_pkg::FLASH_CMD_ERASE_CHIP:   state <= mapper_pkg::ERASE;
                        default:                            state <= mapper_pkg::WAIT_AA;
                    endcase
                end
                mapper_pkg::FAST: begin
                    if (bus.wdata == mapper_pkg::FLASH_CMD_PROGRAM)
                        state <= mapper_pkg::FAST_WRITE;
                    else if (bus.wdata == mapper_pkg::FLASH_CMD_FAST_EXIT)
                        state <= mapper_pkg::WAIT_AA;
                end
                mapper_pkg::FAST_WRITE:   state <= mapper_pkg::FAST;
                mapper_pkg::SINGLE_WRITE: state <= mapper_pkg::WAIT_AA;
                mapper_pkg::ERASE:
                    if (bus.wdata == mapper_pkg::FLASH_UNLOCK1) state <= mapper_pkg::WAIT_55;
                    else state <= mapper_pkg::WAIT_AA;
                default: state <= mapper_pkg::WAIT_AA;
            endcase
        end
    end

    // fast mode and erase hide the RAM window contents
    assign pass_read = ~flash_emu_enabled | ~region.in_ram_area |
        (state != mapper_pkg::FAST && state != mapper_pkg::ERASE);
    assign pass_write = ~flash_emu_enabled | ~region.in_ram_area |
        (state == mapper_pkg::SINGLE_WRITE || state == mapper_pkg::FAST_WRITE);

    // erased flash reads as all ones
    assign catch_val = (state == mapper_pkg::ERASE) ? 8'hFF : 8'h00;

endmodule

/* logic/bank_decode.sv */
`timescale 1ns/100ps

module bank_decode (
    input  mapper_pkg::cart_bus_t                 bus,
    input  mapper_pkg::bank_state_t               bank,
    output mapper_pkg::region_t                   region,
    output logic [mapper_pkg::ADDR_EXT_W-1:0]     addr_ext
);

    logic [mapper_pkg::ROM_EXT_W-1:0] rom_fin;
    logic [mapper_pkg::ROM_EXT_W-1:0] rom_masked;
    logic [mapper_pkg::RAM_EXT_W-1:0] ram_masked;
    logic                             rom_space;
    logic                             ram_space;
    logic                             in_ram_area;
    logic                             apply_mask;

    // window selection by addr_hi
    always_comb begin
        rom_fin     = '0;
        rom_space   = 1'b0;
        ram_space   = 1'b0;
        in_ram_area = 1'b0;
        apply_mask  = 1'b1;
        case (bus.addr_hi)
            4'h0: begin
            end
            4'h1: begin
                // self_flash turns the RAM window into ROM space
                rom_space   = bank.self_flash;
                ram_space   = ~bank.self_flash;
                in_ram_area = 1'b1;
                rom_fin     = bank.ram_bank[mapper_pkg::ROM_EXT_W-1:0];
                apply_mask  = bank.apply_ram;
            end
            4'h2: begin
                rom_space  = 1'b1;
                rom_fin    = bank.rom0_bank[mapper_pkg::ROM_EXT_W-1:0];
                apply_mask = bank.apply_rom0;
            end
            4'h3: begin
                rom_space  = 1'b1;
                rom_fin    = bank.rom1_bank[mapper_pkg::ROM_EXT_W-1:0];
                apply_mask = bank.apply_rom1;
            end
            default: begin
                // linear area is always masked
                rom_space = 1'b1;
                rom_fin   = {bank.linear_off[4:0], bus.addr_hi};
            end
        endcase
    end

    assign rom_masked = apply_mask ? (rom_fin & bank.rom_mask) : rom_fin;
    // SRAM is always banked through the RAM bank register
    assign ram_masked = apply_mask ? (bank.ram_bank[mapper_pkg::RAM_EXT_W-1:0] & bank.ram_mask)
                                   : bank.ram_bank[mapper_pkg::RAM_EXT_W-1:0];

    always_comb begin
        region.rom_space   = rom_space;
        region.ram_space   = ram_space;
        region.in_ram_area = in_ram_area;
        region.psram1_hit  = rom_space && rom_masked[8:7] == 2'b00;
        region.psram2_hit  = rom_space && rom_masked[8:7] == 2'b01;
        region.sram_hit    = ram_space && !ram_masked[3] && bank.enable_sram;
    end

    // SRAM only decodes the low three bank bits
    assign addr_ext[2:0] = rom_space ? rom_masked[2:0] : ram_masked[2:0];
    assign addr_ext[6:3] = rom_masked[6:3];

endmodule

/* logic/cart_regs.sv */
`timescale 1ns/100ps

module cart_regs (
    input  logic                     SClk,
    input  logic                     rst_n,
    input  mapper_pkg::cart_bus_t    bus,
    output mapper_pkg::bank_state_t  bank,
    output logic                     flash_emu_enabled,
    output logic [7:0]               reg_rdata,
    output logic                     reg_ack
);

    // extension enables from POW_CNT
    logic en_nile;
    logic en_2001;
    logic en_2003;

    logic [7:0] reg_addr;
    logic [7:0] wdata;
    logic       io_write;

    // port number is addr_hi over the low nibble of addr_lo
    assign reg_addr = {bus.addr_hi, bus.addr_lo[3:0]};
    assign wdata    = bus.wdata;
    assign io_write = ~bus.sel_n & ~bus.we_n & ~bus.io_n;

    always_ff @(posedge SClk or negedge rst_n) begin
        if (!rst_n) begin
            bank.ram_bank     <= mapper_pkg::BANK_RESET;
            bank.rom0_bank    <= mapper_pkg::BANK_RESET;
            bank.rom1_bank    <= mapper_pkg::BANK_RESET;
            bank.linear_off   <= mapper_pkg::LINEAR_RESET;
            bank.rom_mask     <= mapper_pkg::ROM_MASK_RESET;
            bank.ram_mask     <= mapper_pkg::RAM_MASK_RESET;
            bank.apply_rom0   <= 1'b1;
            bank.apply_rom1   <= 1'b1;
            bank.apply_ram    <= 1'b1;
            bank.self_flash   <= 1'b0;
            bank.enable_sram  <= 1'b1;
            en_nile           <= 1'b1;
            en_2001           <= 1'b1;
            en_2003           <= 1'b1;
            flash_emu_enabled <= 1'b0;
        end else if (io_write) begin
            case (reg_addr)
                // 2001 ports always reach the low bank bits
                mapper_pkg::REG_LINEAR_OFF: bank.linear_off <= wdata;
                mapper_pkg::REG_RAM_BANK:   bank.ram_bank[7:0] <= wdata;
                mapper_pkg::REG_ROM_BANK0:  bank.rom0_bank[7:0] <= wdata;
                mapper_pkg::REG_ROM_BANK1:  bank.rom1_bank[7:0] <= wdata;

                mapper_pkg::REG_RAM_BANK_L:
                    if (en_2003) bank.ram_bank[7:0] <= wdata;
                mapper_pkg::REG_ROM_BANK0_L:
                    if (en_2003) bank.rom0_bank[7:0] <= wdata;
                mapper_pkg::REG_ROM_BANK1_L:
                    if (en_2003) bank.rom1_bank[7:0] <= wdata;
                mapper_pkg::REG_RAM_BANK_H:
                    if (en_2003) bank.ram_bank[9:8] <= wdata[1:0];
                mapper_pkg::REG_ROM_BANK0_H:
                    if (en_2003) bank.rom0_bank[9:8] <= wdata[1:0];
                mapper_pkg::REG_ROM_BANK1_H:
                    if (en_2003) bank.rom1_bank[9:8] <= wdata[1:0];
                mapper_pkg::REG_MEM_CTRL:
                    if (en_2003) bank.self_flash <= wdata[0];

                mapper_pkg::REG_BANK_MASK_LO:
                    if (en_nile) bank.rom_mask[7:0] <= wdata;
                mapper_pkg::REG_BANK_MASK_HI: begin
                    if (en_nile) begin
                        bank.rom_mask[8] <= wdata[0];
                        bank.apply_rom0  <= wdata[1];
                        bank.apply_rom1  <= wdata[2];
                        bank.apply_ram   <= wdata[3];
                        bank.ram_mask    <= wdata[7:4];
                    end
                end

                mapper_pkg::REG_POW_CNT: begin
                    if (en_nile || wdata == mapper_pkg::POW_UNLOCK) begin
                        en_nile          <= wdata[2];
                        en_2001          <= wdata[3];
                        en_2003          <= wdata[4];
                        bank.enable_sram <= wdata[6];
                    end
                end

                mapper_pkg::REG_EMU_CNT:
                    if (en_nile) flash_emu_enabled <= wdata[2];

                default: begin
                end
            endcase
        end
    end

    always_comb begin
        reg_rdata = 8'h00;
        reg_ack   = 1'b1;
        case (reg_addr)
            mapper_pkg::REG_LINEAR_OFF:  reg_rdata = bank.linear_off;
            mapper_pkg::REG_RAM_BANK:    reg_rdata = bank.ram_bank[7:0];
            mapper_pkg::REG_ROM_BANK0:   reg_rdata = bank.rom0_bank[7:0];
            mapper_pkg::REG_ROM_BANK1:   reg_rdata = bank.rom1_bank[7:0];
            mapper_pkg::REG_RAM_BANK_L:  reg_rdata = bank.ram_bank[7:0];
            mapper_pkg::REG_ROM_BANK0_L: reg_rdata = bank.rom0_bank[7:0];
            mapper_pkg::REG_ROM_BANK1_L: reg_rdata = bank.rom1_bank[7:0];
            mapper_pkg::REG_RAM_BANK_H:  reg_rdata = {6'h00, bank.ram_bank[9:8]};
            mapper_pkg::REG_ROM_BANK0_H: reg_rdata = {6'h00, bank.rom0_bank[9:8]};
            mapper_pkg::REG_ROM_BANK1_H: reg_rdata = {6'h00, bank.rom1_bank[9:8]};
            mapper_pkg::REG_MEM_CTRL:    reg_rdata = {7'h00, bank.self_flash};
            mapper_pkg::REG_BANK_MASK_LO: reg_rdata = bank.rom_mask[7:0];
            mapper_pkg::REG_BANK_MASK_HI: begin
                reg_rdata = {bank.ram_mask, bank.apply_ram, bank.apply_rom1,
                             bank.apply_rom0, bank.rom_mask[8]};
            end
            // bits 0, 1, 5 and 7 are not stored
            mapper_pkg::REG_POW_CNT: begin
                reg_rdata = {1'b0, bank.enable_sram, 1'b0, en_2003, en_2001,
                             en_nile, 2'b00};
            end
            mapper_pkg::REG_EMU_CNT: reg_rdata = {5'h00, flash_emu_enabled, 2'b00};
            default: reg_ack = 1'b0;
        endcase
    end

endmodule

/* logic/mapper_pkg.sv */
package mapper_pkg;

    // widths of the bank registers and the external address
    localparam int BANK_W     = 10;
    localparam int ROM_EXT_W  = 9;
    localparam int RAM_EXT_W  = 4;
    localparam int ADDR_EXT_W = 7;

    // Bandai 2001 ports
    localparam logic [7:0] REG_LINEAR_OFF = 8'hC0;
    localparam logic [7:0] REG_RAM_BANK   = 8'hC1;
    localparam logic [7:0] REG_ROM_BANK0  = 8'hC2;
    localparam logic [7:0] REG_ROM_BANK1  = 8'hC3;

    // Bandai 2003 ports
    localparam logic [7:0] REG_MEM_CTRL    = 8'hCE;
    localparam logic [7:0] REG_RAM_BANK_L  = 8'hD0;
    localparam logic [7:0] REG_RAM_BANK_H  = 8'hD1;
    localparam logic [7:0] REG_ROM_BANK0_L = 8'hD2;
    localparam logic [7:0] REG_ROM_BANK0_H = 8'hD3;
    localparam logic [7:0] REG_ROM_BANK1_L = 8'hD4;
    localparam logic [7:0] REG_ROM_BANK1_H = 8'hD5;

    // nileswan extension ports
    localparam logic [7:0] REG_POW_CNT      = 8'hE2;
    localparam logic [7:0] REG_BANK_MASK_LO = 8'hE4;
    localparam logic [7:0] REG_BANK_MASK_HI = 8'hE5;
    localparam logic [7:0] REG_EMU_CNT      = 8'hE6;

    // flash command bytes
    localparam logic [7:0] FLASH_UNLOCK1          = 8'hAA;
    localparam logic [7:0] FLASH_UNLOCK2          = 8'h55;
    localparam logic [7:0] FLASH_CMD_FAST         = 8'h20;
    localparam logic [7:0] FLASH_CMD_PROGRAM      = 8'hA0;
    localparam logic [7:0] FLASH_CMD_ERASE_SECTOR = 8'h30;
    localparam logic [7:0] FLASH_CMD_ERASE_CHIP   = 8'h10;
    localparam logic [7:0] FLASH_CMD_FAST_EXIT    = 8'h90;
    // writing this to POW_CNT works even while the extension is locked
    localparam logic [7:0] POW_UNLOCK             = 8'hFD;

    localparam logic [BANK_W-1:0]    BANK_RESET     = '1;
    localparam logic [7:0]           LINEAR_RESET   = 8'hFF;
    localparam logic [ROM_EXT_W-1:0] ROM_MASK_RESET = 9'h1FF;
    localparam logic [RAM_EXT_W-1:0] RAM_MASK_RESET = 4'hF;

    // one sampled cartridge access, strobes active low
    typedef struct packed {
        logic       sel_n;
        logic       oe_n;
        logic       we_n;
        logic       io_n;
        logic [3:0] addr_hi;
        logic [8:0] addr_lo;
        logic [7:0] wdata;
    } cart_bus_t;

    typedef struct packed {
        logic psram1_sel_n;
        logic psram2_sel_n;
        logic sram_sel_n;
        logic psram_lb_n;
        logic psram_ub_n;
    } mem_sel_t;

    typedef struct packed {
        logic [BANK_W-1:0]    ram_bank;
        logic [BANK_W-1:0]    rom0_bank;
        logic [BANK_W-1:0]    rom1_bank;
        logic [7:0]           linear_off;
        logic [ROM_EXT_W-1:0] rom_mask;
        logic [RAM_EXT_W-1:0] ram_mask;
        logic                 apply_rom0;
        logic                 apply_rom1;
        logic                 apply_ram;
        logic                 self_flash;
        logic                 enable_sram;
    } bank_state_t;

    typedef struct packed {
        logic rom_space;
        logic ram_space;
        logic in_ram_area;
        logic psram1_hit;
        logic psram2_hit;
        logic sram_hit;
    } region_t;

    typedef enum logic [2:0] {
        WAIT_AA,
        WAIT_55,
        CMD,
        FAST,
        FAST_WRITE,
        SINGLE_WRITE,
        ERASE
    } flash_state_e;

endpackage
